// ==== Makefile ====
.PHONY: sim clean

# build and run, status follows the pass message in the output
sim:
	verilator --binary --timing --assert -f tb.f \
		--top-module tb_reservation_station -Mdir obj_dir
	./obj_dir/Vtb_reservation_station | tee /dev/stderr | \
		grep -F '*** PASSED ***' > /dev/null

clean:
	rm -rf obj_dir

// ==== logic/reservation_station.sv ====
`default_nettype none

module reservation_station (
    input  logic                                          clk,
    input  logic                                          rst,
    input  rs_types_pkg::dispatch_t                        dispatch,
    input  rs_types_pkg::cdb_bus_t                         cdb,
    input  logic [rs_cfg_pkg::NUM_CLASS-1:0]              fu_busy,
    output rs_types_pkg::issue_t [rs_cfg_pkg::NUM_CLASS-1:0] issue,
    output logic [rs_cfg_pkg::NUM_CLASS-1:0]              full
);
    import rs_cfg_pkg::*;

    // every bank sees the same dispatch and buses and filters by class itself
    rs_bank #(.BANK_CLASS(CLASS_ADD), .DEPTH(ADD_DEPTH)) bank_add_i (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch),
        .cdb      (cdb),
        .fu_busy  (fu_busy[CLASS_ADD]),
        .issue    (issue[CLASS_ADD]),
        .full     (full[CLASS_ADD])
    );

    rs_bank #(.BANK_CLASS(CLASS_MUL), .DEPTH(MUL_DEPTH)) bank_mul_i (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch),
        .cdb      (cdb),
        .fu_busy  (fu_busy[CLASS_MUL]),
        .issue    (issue[CLASS_MUL]),
        .full     (full[CLASS_MUL])
    );

    rs_bank #(.BANK_CLASS(CLASS_DIV), .DEPTH(DIV_DEPTH)) bank_div_i (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch),
        .cdb      (cdb),
        .fu_busy  (fu_busy[CLASS_DIV]),
        .issue    (issue[CLASS_DIV]),
        .full     (full[CLASS_DIV])
    );

    rs_bank #(.BANK_CLASS(CLASS_BR), .DEPTH(BR_DEPTH)) bank_br_i (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch),
        .cdb      (cdb),
        .fu_busy  (fu_busy[CLASS_BR]),
        .issue    (issue[CLASS_BR]),
        .full     (full[CLASS_BR])
    );

    rs_bank #(.BANK_CLASS(CLASS_MEM), .DEPTH(MEM_DEPTH)) bank_mem_i (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch),
        .cdb      (cdb),
        .fu_busy  (fu_busy[CLASS_MEM]),
        .issue    (issue[CLASS_MEM]),
        .full     (full[CLASS_MEM])
    );

endmodule

`default_nettype wire

// ==== logic/rs_bank.sv ====
`default_nettype none

module rs_bank #(
    parameter rs_cfg_pkg::fu_class_e BANK_CLASS = rs_cfg_pkg::CLASS_ADD,
    parameter int                    DEPTH      = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  rs_types_pkg::dispatch_t dispatch,
    input  rs_types_pkg::cdb_bus_t  cdb,
    input  logic                   fu_busy,
    output rs_types_pkg::issue_t    issue,
    output logic                   full
);
    import rs_cfg_pkg::*;
    import rs_types_pkg::*;

    rs_entry_t        entries [DEPTH];
    rs_entry_t        new_entry;
    rs_entry_t        picked; // entry at ready_idx
    logic [DEPTH-1:0] busy_vec;
    logic [DEPTH-1:0] ready_vec;
    slot_idx_t        free_idx;
    slot_idx_t        ready_idx;
    logic             free_any;
    logic             ready_any;
    logic             insert;
    logic             take;

    always_comb
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            busy_vec[i]  = entries[i].busy;
            ready_vec[i] = entries[i].busy && entries[i].ps1_v && entries[i].ps2_v;
        end
    end

    rs_slot_pick #(
        .DEPTH(DEPTH)
    ) pick_i (
        .busy      (busy_vec),
        .ready     (ready_vec),
        .free_idx  (free_idx),
        .free_any  (free_any),
        .ready_idx (ready_idx),
        .ready_any (ready_any)
    );

    assign insert = dispatch.valid && (dispatch.fu_class == BANK_CLASS) && free_any;
    assign take   = ready_any && !fu_busy; // unit can accept this cycle
    assign full   = ~free_any;

    // a result on the bus this cycle counts as ready for the new entry too
    always_comb
    begin
        new_entry.busy    = 1'b1;
        new_entry.ps1     = dispatch.ps1;
        new_entry.ps1_v   = dispatch.ps1_ready || tag_woken(dispatch.ps1, cdb);
        new_entry.ps2     = dispatch.ps2;
        new_entry.ps2_v   = dispatch.ps2_ready || tag_woken(dispatch.ps2, cdb);
        new_entry.pd      = dispatch.pd;
        new_entry.rd      = dispatch.rd;
        new_entry.rob_idx = dispatch.rob_idx;
        new_entry.info    = dispatch.info;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                entries[i].busy <= 1'b0;
            end
        end
        else
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                if (tag_woken(entries[i].ps1, cdb))
                begin
                    entries[i].ps1_v <= 1'b1;
                end
                if (tag_woken(entries[i].ps2, cdb))
                begin
                    entries[i].ps2_v <= 1'b1;
                end
                if (take && (ready_idx == slot_idx_t'(i)))
                begin
                    entries[i].busy <= 1'b0; // issued, slot free next cycle
                end
                if (insert && (free_idx == slot_idx_t'(i)))
                begin
                    entries[i] <= new_entry; // never the issuing slot
                end
            end
        end
    end

    always_comb
    begin
        picked = entries[0];
        for (int i = 1; i < DEPTH; i++)
        begin
            if (ready_idx == slot_idx_t'(i))
            begin
                picked = entries[i];
            end
        end
    end

    assign issue = '{
        valid:   take,
        ps1:     picked.ps1,
        ps2:     picked.ps2,
        pd:      picked.pd,
        rd:      picked.rd,
        rob_idx: picked.rob_idx,
        info:    picked.info
    };

    a_insert_free: assert property (@(posedge clk) disable iff (rst)
        insert |-> !(|(busy_vec & (DEPTH'(1) << free_idx))));

    a_issue_ready: assert property (@(posedge clk) disable iff (rst)
        issue.valid |-> (picked.busy && picked.ps1_v && picked.ps2_v));

    // a stalled bank keeps every waiting entry
    a_issue_stall: assert property (@(posedge clk) disable iff (rst)
        fu_busy |=> ((busy_vec & $past(busy_vec)) == $past(busy_vec)));

endmodule

`default_nettype wire

// ==== logic/rs_cfg_pkg.sv ====
`default_nettype none

package rs_cfg_pkg;

    localparam int PREG_W = 6; // physical register tag
    localparam int AREG_W = 5; // architectural register
    localparam int ROB_W  = 6;
    localparam int INFO_W = 16; // opaque to the issue stage

    localparam int NUM_CLASS = 5;
    localparam int NUM_CDB   = 5; // one result bus per unit

    // entries per bank
    localparam int ADD_DEPTH = 4;
    localparam int MUL_DEPTH = 2;
    localparam int DIV_DEPTH = 2;
    localparam int BR_DEPTH  = 2;
    localparam int MEM_DEPTH = 4;

    // slot index sized for the deepest bank
    localparam int MAX_DEPTH = 4;
    localparam int SLOT_W    = $clog2(MAX_DEPTH);

    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [AREG_W-1:0] areg_t;
    typedef logic [ROB_W-1:0]  rob_idx_t;
    typedef logic [INFO_W-1:0] decode_info_t;
    typedef logic [SLOT_W-1:0] slot_idx_t;

    // also the bit position in the per-class busy and full vectors
    typedef enum logic [2:0] {
        CLASS_ADD = 3'd0,
        CLASS_MUL = 3'd1,
        CLASS_DIV = 3'd2,
        CLASS_BR  = 3'd3,
        CLASS_MEM = 3'd4
    } fu_class_e;

endpackage

`default_nettype wire

// ==== logic/rs_slot_pick.sv ====
`default_nettype none

module rs_slot_pick #(
    parameter int DEPTH = 4
) (
    input  logic [DEPTH-1:0]      busy,
    input  logic [DEPTH-1:0]      ready,
    output rs_cfg_pkg::slot_idx_t free_idx,
    output logic                  free_any,
    output rs_cfg_pkg::slot_idx_t ready_idx,
    output logic                  ready_any
);
    import rs_cfg_pkg::*;

    logic chosen_busy; // busy bit behind ready_idx

    // scan top down so the lowest index is written last and wins
    always_comb
    begin
        free_idx  = '0;
        ready_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                free_idx = slot_idx_t'(i);
            end
            if (ready[i])
            begin
                ready_idx = slot_idx_t'(i);
            end
        end
    end

    assign free_any  = ~&busy;
    assign ready_any = |ready;

    always_comb
    begin
        chosen_busy = 1'b0;
        for (int i = 0; i < DEPTH; i++)
        begin
            if (ready_idx == slot_idx_t'(i))
            begin
                chosen_busy = busy[i];
            end
        end
        // ready vector comes from the bank, so this ties both sides together
        assert (!ready_any || chosen_busy)
            else $error("rs_slot_pick: ready slot %0d not busy", ready_idx);
    end

endmodule

`default_nettype wire

// ==== logic/rs_types_pkg.sv ====
`default_nettype none

package rs_types_pkg;
    import rs_cfg_pkg::*;

    // one operation from rename/dispatch
    typedef struct packed {
        logic         valid;
        fu_class_e    fu_class; // picks the bank
        preg_t        ps1;
        logic         ps1_ready;
        preg_t        ps2;
        logic         ps2_ready;
        preg_t        pd;
        areg_t        rd;
        rob_idx_t     rob_idx;
        decode_info_t info;
    } dispatch_t;

    // a finished result announced on the common data bus
    typedef struct packed {
        logic  valid;
        preg_t tag;
    } cdb_t;

    typedef cdb_t [NUM_CDB-1:0] cdb_bus_t;

    typedef struct packed {
        logic         busy;  // slot holds a waiting op
        preg_t        ps1;
        logic         ps1_v; // operand 1 available
        preg_t        ps2;
        logic         ps2_v;
        preg_t        pd;
        areg_t        rd;
        rob_idx_t     rob_idx;
        decode_info_t info;
    } rs_entry_t;

    typedef struct packed {
        logic         valid;
        preg_t        ps1;
        preg_t        ps2;
        preg_t        pd;
        areg_t        rd;
        rob_idx_t     rob_idx;
        decode_info_t info;
    } issue_t;

    // a tag wakes only on a bus with valid set
    function automatic logic tag_woken(input preg_t tag, input cdb_bus_t cdb);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NUM_CDB; i++)
        begin
            if (cdb[i].valid && (cdb[i].tag == tag))
            begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

endpackage

`default_nettype wire

// ==== tb.f ====
logic/rs_cfg_pkg.sv
logic/rs_types_pkg.sv
logic/rs_slot_pick.sv
logic/rs_bank.sv
logic/reservation_station.sv
tests/tb_reservation_station.sv

// ==== tests/tb_reservation_station.sv ====
`default_nettype none

module tb_reservation_station;
    import rs_cfg_pkg::*;
    import rs_types_pkg::*;

    localparam int CYCLE         = 40;
    localparam int RESET_CYCLES  = 16;
    localparam int RANDOM_CYCLES = 2000;
    // reset, directed tests, random mix, final drain
    localparam int TEST_CYCLES   = RESET_CYCLES + 16 + 6 + 4 + 14 + RANDOM_CYCLES + 4;
    localparam int SEED          = 32'h6c3e6fd9;

    logic                   clk;
    logic                   rst;
    dispatch_t              dispatch;
    cdb_bus_t               cdb;
    logic [NUM_CLASS-1:0]   fu_busy;
    issue_t [NUM_CLASS-1:0] issue;
    logic [NUM_CLASS-1:0]   full;

    rs_entry_t model [NUM_CLASS][MAX_DEPTH]; // expected contents of every bank
    int        errors;
    int        checks;
    int        tests_run;
    int        errors_at_start;

    reservation_station dut_i (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch),
        .cdb      (cdb),
        .fu_busy  (fu_busy),
        .issue    (issue),
        .full     (full)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CYCLE / 2) clk = ~clk;
    end

    function automatic int bank_depth(input int c);
        case (c)
            0: return ADD_DEPTH;
            1: return MUL_DEPTH;
            2: return DIV_DEPTH;
            3: return BR_DEPTH;
            default: return MEM_DEPTH;
        endcase
    endfunction

    // only a bus with valid set carries a result
    function automatic logic on_bus(input preg_t tag);
        for (int b = 0; b < NUM_CDB; b++)
        begin
            if (cdb[b].valid && (cdb[b].tag == tag))
            begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic int lowest_free(input int c);
        int idx;
        idx = -1;
        for (int s = bank_depth(c) - 1; s >= 0; s--)
        begin
            if (!model[c][s].busy)
            begin
                idx = s;
            end
        end
        return idx;
    endfunction

    function automatic int lowest_ready(input int c);
        int idx;
        idx = -1;
        for (int s = bank_depth(c) - 1; s >= 0; s--)
        begin
            if (model[c][s].busy && model[c][s].ps1_v && model[c][s].ps2_v)
            begin
                idx = s;
            end
        end
        return idx;
    endfunction

    // what bank c must show on its issue port this cycle
    function automatic issue_t expect_issue(input int c);
        issue_t want;
        int     s;
        want = '0;
        s = lowest_ready(c);
        if (!fu_busy[c] && (s >= 0))
        begin
            want.valid   = 1'b1;
            want.ps1     = model[c][s].ps1;
            want.ps2     = model[c][s].ps2;
            want.pd      = model[c][s].pd;
            want.rd      = model[c][s].rd;
            want.rob_idx = model[c][s].rob_idx;
            want.info    = model[c][s].info;
        end
        return want;
    endfunction

    // advance the model over one clock edge
    task automatic step_model();
        int        go;
        int        put;
        rs_entry_t e;
        for (int c = 0; c < NUM_CLASS; c++)
        begin
            go  = fu_busy[c] ? -1 : lowest_ready(c);
            put = lowest_free(c); // picked before this edge frees anything
            for (int s = 0; s < bank_depth(c); s++)
            begin
                if (on_bus(model[c][s].ps1))
                begin
                    model[c][s].ps1_v = 1'b1;
                end
                if (on_bus(model[c][s].ps2))
                begin
                    model[c][s].ps2_v = 1'b1;
                end
            end
            if (go >= 0)
            begin
                model[c][go].busy = 1'b0;
            end
            if (dispatch.valid && (int'(dispatch.fu_class) == c) && (put >= 0))
            begin
                e.busy    = 1'b1;
                e.ps1     = dispatch.ps1;
                e.ps1_v   = dispatch.ps1_ready || on_bus(dispatch.ps1); // same-cycle bypass
                e.ps2     = dispatch.ps2;
                e.ps2_v   = dispatch.ps2_ready || on_bus(dispatch.ps2);
                e.pd      = dispatch.pd;
                e.rd      = dispatch.rd;
                e.rob_idx = dispatch.rob_idx;
                e.info    = dispatch.info;
                model[c][put] = e;
            end
        end
    endtask

    // outputs are settled by the falling edge, inputs change only on the rising one
    always @(negedge clk)
    begin
        issue_t want;
        logic   want_full;
        if (rst)
        begin
            for (int c = 0; c < NUM_CLASS; c++)
            begin
                for (int s = 0; s < MAX_DEPTH; s++)
                begin
                    model[c][s] = '0;
                end
            end
        end
        else
        begin
            for (int c = 0; c < NUM_CLASS; c++)
            begin
                want      = expect_issue(c);
                want_full = (lowest_free(c) < 0);
                checks++;
                if (issue[c].valid !== want.valid)
                begin
                    $display("error: issue[%0d].valid dut=%h exp=%h", c, issue[c].valid,
                             want.valid);
                    errors++;
                end
                else if (want.valid && (issue[c] !== want))
                begin
                    $display("error: issue[%0d] dut=%h exp=%h", c, issue[c], want);
                    errors++;
                end
                if (full[c] !== want_full)
                begin
                    $display("error: full[%0d] dut=%h exp=%h", c, full[c], want_full);
                    errors++;
                end
            end
            step_model();
        end
    end

    function automatic dispatch_t make_op(input fu_class_e c, input preg_t ps1, input logic r1,
                                          input preg_t ps2, input logic r2);
        dispatch_t d;
        d.valid     = 1'b1;
        d.fu_class  = c;
        d.ps1       = ps1;
        d.ps1_ready = r1;
        d.ps2       = ps2;
        d.ps2_ready = r2;
        d.pd        = preg_t'($urandom_range(63));
        d.rd        = areg_t'($urandom_range(31));
        d.rob_idx   = rob_idx_t'($urandom_range(63));
        d.info      = decode_info_t'($urandom_range(16'hffff));
        return d;
    endfunction

    task automatic drive(input dispatch_t d, input cdb_bus_t bus, input logic [NUM_CLASS-1:0] bsy);
        @(posedge clk);
        dispatch <= d;
        cdb      <= bus;
        fu_busy  <= bsy;
    endtask

    // the payload must come out exactly as dispatched
    task automatic expect_issued(input int c, input dispatch_t d);
        issue_t want;
        want = '{valid: 1'b1, ps1: d.ps1, ps2: d.ps2, pd: d.pd, rd: d.rd,
                 rob_idx: d.rob_idx, info: d.info};
        @(negedge clk);
        checks++;
        if (!issue[c].valid)
        begin
            $display("bank %0d did not issue the entry with rob index %h", c, d.rob_idx);
            errors++;
        end
        else if (issue[c] !== want)
        begin
            $display("error: issue[%0d] dut=%h exp=%h", c, issue[c], want);
            errors++;
        end
    endtask

    task automatic expect_quiet(input int c);
        @(negedge clk);
        checks++;
        if (issue[c].valid)
        begin
            $display("bank %0d issued while its entry should still wait", c);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    initial
    begin
        dispatch_t d;
        dispatch_t ops [ADD_DEPTH];
        cdb_bus_t  bus;
        logic [NUM_CLASS-1:0] bsy;
        void'($urandom(SEED));
        rst             = 1'b1;
        dispatch        = '0;
        cdb             = '0;
        fu_busy         = '0;
        errors          = 0;
        checks          = 0;
        tests_run       = 0;
        errors_at_start = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // ready operands go straight through, one class at a time
        @(negedge clk);
        checks++;
        if (full !== '0)
        begin
            $display("error: full dut=%h exp=%h", full, 5'h00);
            errors++;
        end
        for (int c = 0; c < NUM_CLASS; c++)
        begin
            if (issue[c].valid)
            begin
                $display("bank %0d issued right after reset", c);
                errors++;
            end
        end
        for (int c = 0; c < NUM_CLASS; c++)
        begin
            d = make_op(fu_class_e'(c), preg_t'($urandom_range(63)), 1'b1,
                        preg_t'($urandom_range(63)), 1'b1);
            drive(d, '0, '0);
            drive('0, '0, '0);
            expect_issued(c, d);
        end
        finish_test("ready dispatch");

        d = make_op(CLASS_MUL, 6'd12, 1'b0, 6'd7, 1'b1);
        drive(d, '0, '0);
        bus = '0;
        bus[1] = '{valid: 1'b0, tag: 6'd12}; // tag without valid
        drive('0, bus, '0);
        expect_quiet(CLASS_MUL);
        bus = '0;
        bus[3] = '{valid: 1'b1, tag: 6'd12};
        drive('0, bus, '0);
        expect_quiet(CLASS_MUL); // ready bit lands at the edge
        drive('0, '0, '0);
        expect_issued(CLASS_MUL, d);
        finish_test("wakeup by broadcast");

        d = make_op(CLASS_BR, 6'd3, 1'b1, 6'd20, 1'b0);
        bus = '0;
        bus[0] = '{valid: 1'b1, tag: 6'd20};
        drive(d, bus, '0);
        drive('0, '0, '0);
        expect_issued(CLASS_BR, d);
        finish_test("wakeup on dispatch");

        bsy = '0;
        bsy[CLASS_ADD] = 1'b1;
        for (int k = 0; k < ADD_DEPTH; k++)
        begin
            ops[k] = make_op(CLASS_ADD, preg_t'($urandom_range(63)), 1'b1,
                             preg_t'($urandom_range(63)), 1'b1);
            drive(ops[k], '0, bsy);
        end
        drive('0, '0, bsy);
        @(negedge clk);
        checks++;
        if (!full[CLASS_ADD])
        begin
            $display("add bank did not report full after %0d inserts", ADD_DEPTH);
            errors++;
        end
        d = make_op(CLASS_ADD, 6'd1, 1'b1, 6'd2, 1'b1); // dropped, must never show up
        drive(d, '0, bsy);
        for (int k = 0; k < ADD_DEPTH; k++)
        begin
            drive('0, '0, '0);
            expect_issued(CLASS_ADD, ops[k]);
        end
        drive('0, '0, '0);
        expect_quiet(CLASS_ADD);
        finish_test("full and drain");

        for (int n = 0; n < RANDOM_CYCLES; n++)
        begin
            d = make_op(fu_class_e'(3'($urandom_range(4))), preg_t'($urandom_range(15)),
                        1'($urandom_range(1)), preg_t'($urandom_range(15)),
                        1'($urandom_range(1)));
            d.valid = ($urandom_range(9) < 6);
            for (int b = 0; b < NUM_CDB; b++)
            begin
                bus[b].valid = ($urandom_range(3) == 0);
                bus[b].tag   = preg_t'($urandom_range(15));
            end
            for (int c = 0; c < NUM_CLASS; c++)
            begin
                bsy[c] = ($urandom_range(3) == 0);
            end
            drive(d, bus, bsy);
        end
        repeat (3) drive('0, '0, '0);
        @(negedge clk);
        finish_test("random mix");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial
    begin
        #(TEST_CYCLES * CYCLE * 2);
        $display("watchdog: the run did not finish in the expected time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
